/* hdl/g729Pkg.sv */
package g729Pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int NUM_UNITS = 12;                  // Width of start and done vectors

	localparam int DEFAULT_FRAMES_PER_PASS = 2;     // Frame pulses per encoding pass
	localparam int DEFAULT_SUBFRAMES = 2;           // Subframes per pass
	localparam int DEFAULT_SUBFRAME_LEN = 40;       // Samples per subframe

	//////////////////////////////
	// Steps and units
	//////////////////////////////

	// Step code doubles as the datapath mux select
	typedef enum logic [3:0] {
		STEP_AUTOCORR     = 4'd0,
		STEP_LAG_WINDOW   = 4'd1,
		STEP_LEVINSON     = 4'd2,
		STEP_AZ_LSP       = 4'd3,
		STEP_QUA_LSP      = 4'd4,
		STEP_WEIGHT_AZ    = 4'd5,
		STEP_SYN_FILT     = 4'd6,
		STEP_PITCH_FR3    = 4'd7,
		STEP_PARITY_PITCH = 4'd8,
		STEP_ACELP        = 4'd9,
		STEP_QUA_GAIN     = 4'd10,
		STEP_COPY         = 4'd11,
		STEP_NONE         = 4'd15                     // End of chain or body marker
	} stepE;

	typedef enum logic [3:0] {
		UNIT_AUTOCORR     = 4'd0,
		UNIT_LAG_WINDOW   = 4'd1,
		UNIT_LEVINSON     = 4'd2,
		UNIT_AZ_LSP       = 4'd3,
		UNIT_QUA_LSP      = 4'd4,
		UNIT_WEIGHT_AZ    = 4'd5,
		UNIT_SYN_FILT     = 4'd6,
		UNIT_PITCH_FR3    = 4'd7,
		UNIT_PARITY_PITCH = 4'd8,
		UNIT_ACELP        = 4'd9,
		UNIT_QUA_GAIN     = 4'd10,
		UNIT_COPY         = 4'd11
	} unitE;

	function automatic unitE unitOf(input stepE step);
		case (step)
			STEP_LAG_WINDOW:   return UNIT_LAG_WINDOW;
			STEP_LEVINSON:     return UNIT_LEVINSON;
			STEP_AZ_LSP:       return UNIT_AZ_LSP;
			STEP_QUA_LSP:      return UNIT_QUA_LSP;
			STEP_WEIGHT_AZ:    return UNIT_WEIGHT_AZ;
			STEP_SYN_FILT:     return UNIT_SYN_FILT;
			STEP_PITCH_FR3:    return UNIT_PITCH_FR3;
			STEP_PARITY_PITCH: return UNIT_PARITY_PITCH;
			STEP_ACELP:        return UNIT_ACELP;
			STEP_QUA_GAIN:     return UNIT_QUA_GAIN;
			STEP_COPY:         return UNIT_COPY;
			default:           return UNIT_AUTOCORR;
		endcase
	endfunction

	// Walks the LPC chain and the subframe body, parity rule left to the caller
	function automatic stepE nextStep(input stepE step);
		case (step)
			STEP_AUTOCORR:     return STEP_LAG_WINDOW;
			STEP_LAG_WINDOW:   return STEP_LEVINSON;
			STEP_LEVINSON:     return STEP_AZ_LSP;
			STEP_AZ_LSP:       return STEP_QUA_LSP;
			STEP_WEIGHT_AZ:    return STEP_SYN_FILT;
			STEP_SYN_FILT:     return STEP_PITCH_FR3;
			STEP_PITCH_FR3:    return STEP_PARITY_PITCH;
			STEP_PARITY_PITCH: return STEP_ACELP;
			STEP_ACELP:        return STEP_QUA_GAIN;
			default:           return STEP_NONE;      // After QUA_LSP, QUA_GAIN, COPY
		endcase
	endfunction

endpackage

/* hdl/frameGate.sv */
`timescale 1ns/1ps

module frameGate #(
	parameter int FRAMES_PER_PASS = g729Pkg::DEFAULT_FRAMES_PER_PASS
) (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic divErr,
	input  logic frameDone,
	input  logic analysisTaken,
	output logic armed,
	output logic analysisPending,
	output logic abortReq
);

	localparam int CNT_W = (FRAMES_PER_PASS > 1) ? $clog2(FRAMES_PER_PASS) : 1;

	logic [CNT_W-1:0] frameCount;   // Frame pulses seen in the current group
	logic countWrap;                // Last pulse of a group

	assign countWrap = armed && frameDone &&
		(frameCount == CNT_W'(FRAMES_PER_PASS - 1));

	//////////////////////////////
	// Arm, count, pending
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			frameCount <= '0;
			analysisPending <= 1'b0;
			abortReq <= 1'b0;
		end
		else
		begin
			abortReq <= divErr;            // One cycle behind the error
			if (divErr)
			begin
				armed <= 1'b0;
				frameCount <= '0;
				analysisPending <= 1'b0;
			end
			else
			begin
				if (start)
					armed <= 1'b1;
				if (armed && frameDone)
				begin
					if (countWrap)
						frameCount <= '0;
					else
						frameCount <= frameCount + 1'b1;
				end
				// A new group wins over a take in the same cycle
				if (countWrap)
					analysisPending <= 1'b1;
				else if (analysisTaken)
					analysisPending <= 1'b0;
			end
		end
	end

	// Sequencer only takes a pass that was flagged here
	assert property (@(posedge clock) disable iff (reset || abortReq)
		analysisTaken |-> analysisPending)
		else $error("frameGate: analysisTaken without a pending pass");

endmodule

/* hdl/encoderSequencer.sv */
`timescale 1ns/1ps

module encoderSequencer #(
	parameter int SUBFRAMES = g729Pkg::DEFAULT_SUBFRAMES,
	parameter int SUBFRAME_LEN = g729Pkg::DEFAULT_SUBFRAME_LEN
) (
	input  logic clock,
	input  logic reset,
	input  logic armed,
	input  logic analysisPending,
	input  logic abortReq,
	input  logic [g729Pkg::NUM_UNITS-1:0] unitDone,
	output logic analysisTaken,
	output logic issue,
	output g729Pkg::stepE issueStep,
	output logic passEnd,
	output logic [15:0] subframeIdx
);

	import g729Pkg::*;

	localparam int SUB_W = $clog2(SUBFRAMES + 1);

	typedef enum logic [2:0] {
		IDLE,
		WAIT_FRAME,
		ISSUE,
		WAIT_DONE,
		LOOP_CHECK,
		FINISH
	} stateE;

	stateE state;
	stepE curStep;                  // Step in flight or about to issue
	stepE followStep;               // Successor with the parity rule applied
	stepE loopStep;                 // Body start or copy at the loop check
	logic [SUB_W-1:0] subCount;
	logic stepDone;                 // Done bit of the awaited unit

	assign stepDone = unitDone[unitOf(curStep)];
	assign loopStep = (subCount < SUB_W'(SUBFRAMES)) ? STEP_WEIGHT_AZ : STEP_COPY;

	always_comb
	begin
		followStep = nextStep(curStep);
		// Parity pitch belongs to the first subframe only
		if (followStep == STEP_PARITY_PITCH && subCount != '0)
			followStep = nextStep(STEP_PARITY_PITCH);
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// The loop check issues directly so every step follows its done by one cycle
	assign issue = (state == ISSUE) || (state == LOOP_CHECK);
	assign issueStep = (state == LOOP_CHECK) ? loopStep : curStep;
	assign passEnd = (state == FINISH);

	//////////////////////////////
	// State machine
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			curStep <= STEP_AUTOCORR;
			subCount <= '0;
			subframeIdx <= '0;
			analysisTaken <= 1'b0;
		end
		else
		begin
			analysisTaken <= 1'b0;
			if (abortReq)
				state <= IDLE;               // Divide error drops the pass
			else
			begin
				case (state)
					IDLE:
					begin
						if (armed)
							state <= WAIT_FRAME;
					end
					WAIT_FRAME:
					begin
						if (!armed)
							state <= IDLE;
						else if (analysisPending)
						begin
							state <= ISSUE;
							curStep <= STEP_AUTOCORR;
							subCount <= '0;
							subframeIdx <= '0;
							analysisTaken <= 1'b1;
						end
					end
					ISSUE:
						state <= WAIT_DONE;
					WAIT_DONE:
					begin
						if (stepDone)
						begin
							if (curStep == STEP_COPY)
								state <= FINISH;
							else if (curStep == STEP_QUA_GAIN)
							begin
								// Subframe body finished
								subCount <= subCount + 1'b1;
								subframeIdx <= subframeIdx + 16'(SUBFRAME_LEN);
								state <= LOOP_CHECK;
							end
							else if (followStep == STEP_NONE)
							begin
								curStep <= STEP_WEIGHT_AZ;   // LPC chain done
								state <= ISSUE;
							end
							else
							begin
								curStep <= followStep;
								state <= ISSUE;
							end
						end
					end
					LOOP_CHECK:
					begin
						curStep <= loopStep;
						state <= WAIT_DONE;
					end
					FINISH:
					begin
						if (armed)
							state <= WAIT_FRAME;
						else
							state <= IDLE;
					end
					default:
						state <= IDLE;
				endcase
			end
		end
	end

	// A unit must not report done in the cycle its successor is issued
	assert property (@(posedge clock) disable iff (reset)
		issue |-> !stepDone)
		else $error("encoderSequencer: issue collides with an awaited done");

endmodule

/* hdl/unitDispatch.sv */
`timescale 1ns/1ps

module unitDispatch (
	input  logic clock,
	input  logic reset,
	input  logic issue,
	input  g729Pkg::stepE issueStep,
	input  logic passEnd,
	input  logic abortReq,
	output logic [g729Pkg::NUM_UNITS-1:0] unitStart,
	output logic [5:0] mathMuxSel,
	output logic done
);

	import g729Pkg::*;

	logic [NUM_UNITS-1:0] startDecode;   // One-hot of the issued unit

	assign startDecode = NUM_UNITS'(1) << unitOf(issueStep);

	//////////////////////////////
	// Registered outputs
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			unitStart <= '0;
			mathMuxSel <= '0;
			done <= 1'b0;
		end
		else if (abortReq)
		begin
			unitStart <= '0;                 // Nothing leaves after an abort
			mathMuxSel <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (issue)
			begin
				unitStart <= startDecode;
				mathMuxSel <= 6'(issueStep);  // Held until the next issue
			end
			else
				unitStart <= '0;
			done <= passEnd;
		end
	end

	// Each unit start is a single-cycle pulse
	assert property (@(posedge clock) disable iff (reset)
		unitStart != '0 |=> unitStart == '0)
		else $error("unitDispatch: unit start held for more than one cycle");

endmodule

/* hdl/g729Control.sv */
`timescale 1ns/1ps

module g729Control #(
	parameter int FRAMES_PER_PASS = g729Pkg::DEFAULT_FRAMES_PER_PASS,
	parameter int SUBFRAMES = g729Pkg::DEFAULT_SUBFRAMES,
	parameter int SUBFRAME_LEN = g729Pkg::DEFAULT_SUBFRAME_LEN
) (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic divErr,
	input  logic frameDone,
	input  logic [g729Pkg::NUM_UNITS-1:0] unitDone,
	output logic [g729Pkg::NUM_UNITS-1:0] unitStart,
	output logic [5:0] mathMuxSel,
	output logic [15:0] subframeIdx,
	output logic done
);

	import g729Pkg::*;

	logic armed;
	logic analysisPending;
	logic abortReq;
	logic analysisTaken;
	logic issue;
	logic passEnd;
	stepE issueStep;

	//////////////////////////////
	// Frame side, sequencer, dispatch
	//////////////////////////////

	frameGate #(
		.FRAMES_PER_PASS(FRAMES_PER_PASS)
	) u_frameGate (
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameDone(frameDone),
		.analysisTaken(analysisTaken),
		.armed(armed),
		.analysisPending(analysisPending),
		.abortReq(abortReq)
	);

	encoderSequencer #(
		.SUBFRAMES(SUBFRAMES),
		.SUBFRAME_LEN(SUBFRAME_LEN)
	) u_encoderSequencer (
		.clock(clock),
		.reset(reset),
		.armed(armed),
		.analysisPending(analysisPending),
		.abortReq(abortReq),
		.unitDone(unitDone),
		.analysisTaken(analysisTaken),
		.issue(issue),
		.issueStep(issueStep),
		.passEnd(passEnd),
		.subframeIdx(subframeIdx)
	);

	unitDispatch u_unitDispatch (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.issueStep(issueStep),
		.passEnd(passEnd),
		.abortReq(abortReq),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.done(done)
	);

endmodule

/* tests/unitResponder.sv */
`timescale 1ns/1ps

module unitResponder #(
	parameter int WIDTH = 12
) (
	input  logic clock,
	input  logic reset,
	input  logic [WIDTH-1:0] unitStart,
	input  int delay,
	output logic [WIDTH-1:0] unitDone
);

	logic busy;                      // A unit is working
	int remain;                      // Cycles left before its done pulse
	logic [WIDTH-1:0] pendingUnit;   // Start bit being answered

	always @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			remain <= 0;
			pendingUnit <= '0;
			unitDone <= '0;
		end
		else
		begin
			unitDone <= '0;
			if (unitStart != '0)
			begin
				busy <= 1'b1;
				pendingUnit <= unitStart;
				remain <= delay;             // Sampled with the start
			end
			else if (busy)
			begin
				if (remain == 0)
				begin
					unitDone <= pendingUnit;   // Same bit as the start
					busy <= 1'b0;
				end
				else
					remain <= remain - 1;
			end
		end
	end

endmodule

/* tests/g729ControlTb.sv */
`timescale 1ns/1ps

module g729ControlTb;

	import g729Pkg::*;

	localparam int NUM_SCEN = 7;
	localparam int POOL = 64;
	localparam int SUB_LEN = DEFAULT_SUBFRAME_LEN;
	localparam int STARTS_PER_PASS = 7 + 5 * DEFAULT_SUBFRAMES;   // Chain, copy, bodies, parity

	//////////////////////////////
	// Scenario table
	//////////////////////////////

	// One row per scenario with name, passes, delay or random bound, random flag, abort index
	string scenName [NUM_SCEN] = '{"fixed_delay_1", "fixed_delay_0", "random_delay",
		"abort_mid_pass", "after_abort", "abort_first_start", "recover"};
	int passCount [NUM_SCEN] = '{2, 1, 2, 1, 1, 1, 1};
	int delayBound [NUM_SCEN] = '{1, 0, 6, 2, 3, 5, 2};
	bit delayRandom [NUM_SCEN] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
	int abortAt [NUM_SCEN] = '{-1, -1, -1, 8, -1, 0, -1};

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	logic [NUM_UNITS-1:0] unitDone;
	logic [NUM_UNITS-1:0] unitStart;
	logic [5:0] mathMuxSel;
	logic [15:0] subframeIdx;
	logic done;

	int respDelay = 0;
	int delayPool [POOL];
	int curScen = 0;
	stepE expSteps [$];              // Starts still to come in this pass
	int expIdx [$];                  // Matching subframeIdx values
	stepE wantStep;
	int wantIdx;
	int lastSel = 0;
	bit haveSel = 1'b0;
	bit passActive = 1'b0;
	bit copyDoneSeen = 1'b0;
	int startsInPass = 0;
	int startSeen = 0;
	int doneCount = 0;
	int negCount = 0;
	int firstStartNeg = 0;
	int pulseNeg = 0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	g729Control u_g729Control (
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameDone(frameDone),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.subframeIdx(subframeIdx),
		.done(done)
	);

	unitResponder #(
		.WIDTH(NUM_UNITS)
	) u_unitResponder (
		.clock(clock),
		.reset(reset),
		.unitStart(unitStart),
		.delay(respDelay),
		.unitDone(unitDone)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic compareValue(input string what, input int expected, input int actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("[FAIL] %s: %s expected %0d actual %0d", scenName[curScen], what,
				expected, actual);
		end
	endtask

	task automatic requireThat(input bit ok, input string problem);
		checkCount++;
		assert (ok)
		else
		begin
			errorCount++;
			$display("Error in %s: %s", scenName[curScen], problem);
		end
	endtask

	// Successor in the LPC chain or subframe body, STEP_NONE at the end of either
	function automatic stepE followingStep(input stepE s);
		if (s == STEP_QUA_LSP || s == STEP_QUA_GAIN || s == STEP_COPY)
			return STEP_NONE;
		return stepE'(s + 4'd1);
	endfunction

	function automatic int abortWindow(input int s);
		return 3 * (delayBound[s] + 4) + 10;
	endfunction

	function automatic int cycleLimit();
		int total;
		int s;
		total = 16;
		for (s = 0; s < NUM_SCEN; s++)
		begin
			total += passCount[s] * (STARTS_PER_PASS * (delayBound[s] + 4) + 30);
			total += abortWindow(s) + 10;
		end
		return 2 * total;               // Margin over the estimate
	endfunction

	task automatic buildStartOrder();
		stepE s;
		int sub;
		expSteps.delete();
		expIdx.delete();
		s = STEP_AUTOCORR;
		while (s != STEP_NONE)
		begin
			expSteps.push_back(s);
			expIdx.push_back(0);
			s = followingStep(s);
		end
		for (sub = 0; sub < DEFAULT_SUBFRAMES; sub++)
		begin
			s = STEP_WEIGHT_AZ;
			while (s != STEP_NONE)
			begin
				if (s != STEP_PARITY_PITCH || sub == 0)   // Parity in first subframe only
				begin
					expSteps.push_back(s);
					expIdx.push_back(sub * SUB_LEN);
				end
				s = followingStep(s);
			end
		end
		expSteps.push_back(STEP_COPY);
		expIdx.push_back(DEFAULT_SUBFRAMES * SUB_LEN);
	endtask

	task automatic runPass(input int abortIdx);
		int doneBefore;
		// A lone frame pulse must not release a pass
		@(posedge clock);
		frameDone <= 1'b1;
		@(posedge clock);
		frameDone <= 1'b0;
		repeat (8) @(posedge clock);
		buildStartOrder();
		startsInPass = 0;
		copyDoneSeen = 1'b0;
		passActive = 1'b1;
		doneBefore = doneCount;
		frameDone <= 1'b1;
		pulseNeg = negCount;
		@(posedge clock);
		frameDone <= 1'b0;
		if (abortIdx < 0)
		begin
			while (doneCount == doneBefore)
				@(posedge clock);
			repeat (4) @(posedge clock);   // Room for a stray second done
			passActive = 1'b0;
			compareValue("starts in pass", STARTS_PER_PASS, startsInPass);
			compareValue("done pulses", doneBefore + 1, doneCount);
		end
		else
		begin
			while (startsInPass <= abortIdx)
				@(posedge clock);
			divErr <= 1'b1;
			start <= 1'b0;
			passActive = 1'b0;
			haveSel = 1'b0;                // Abort clears the select
			expSteps.delete();
			expIdx.delete();
			@(posedge clock);
			divErr <= 1'b0;
			repeat (abortWindow(curScen)) @(posedge clock);
			compareValue("starts after abort", abortIdx + 1, startsInPass);
			compareValue("done pulses after abort", doneBefore, doneCount);
		end
		compareValue("first start latency", 3, firstStartNeg - pulseNeg - 1);
	endtask

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	always @(negedge clock)
	begin
		negCount++;
		if (!reset)
		begin
			if (unitDone[STEP_COPY])
				copyDoneSeen = 1'b1;
			if (unitStart != '0)
			begin
				if (startsInPass == 0)
					firstStartNeg = negCount;
				startsInPass++;
				respDelay = delayRandom[curScen] ?
					delayPool[startSeen % POOL] % (delayBound[curScen] + 1) : delayBound[curScen];
				startSeen++;
				requireThat(expSteps.size() != 0, "unit start when none was expected");
				if (expSteps.size() != 0)
				begin
					wantStep = expSteps.pop_front();
					wantIdx = expIdx.pop_front();
					compareValue("unitStart", 1 << int'(wantStep), int'(unitStart));
					compareValue("mathMuxSel at start", int'(wantStep), int'(mathMuxSel));
					compareValue("subframeIdx", wantIdx, int'(subframeIdx));
					lastSel = int'(wantStep);
					haveSel = 1'b1;
				end
			end
			else if (passActive && haveSel)
				compareValue("mathMuxSel held", lastSel, int'(mathMuxSel));
			if (done)
			begin
				doneCount++;
				requireThat(passActive, "done pulse outside a pass");
				requireThat(expSteps.size() == 0, "done pulse before the last unit start");
				requireThat(copyDoneSeen, "done pulse before the copy unit finished");
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int s;
		int p;
		int i;
		void'($urandom(32'h6fa9_e8c4));
		for (i = 0; i < POOL; i++)
			delayPool[i] = int'($urandom % 32'd16);
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compareValue("unitStart after reset", 0, int'(unitStart));
		compareValue("mathMuxSel after reset", 0, int'(mathMuxSel));
		compareValue("subframeIdx after reset", 0, int'(subframeIdx));
		compareValue("done after reset", 0, int'(done));
		for (s = 0; s < NUM_SCEN; s++)
		begin
			@(posedge clock);
			curScen = s;
			start <= 1'b1;
			repeat (4) @(posedge clock);   // Let the gate arm
			for (p = 0; p < passCount[s]; p++)
				runPass((p == passCount[s] - 1) ? abortAt[s] : -1);
		end
		repeat (4) @(posedge clock);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Run limit
	initial
	begin
		int limit;
		@(posedge clock);
		limit = cycleLimit();
		while (cycleCount < limit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* g729Control.f */
hdl/g729Pkg.sv
hdl/frameGate.sv
hdl/encoderSequencer.sv
hdl/unitDispatch.sv
hdl/g729Control.sv
tests/unitResponder.sv
tests/g729ControlTb.sv

/* run.sh */
#!/bin/sh
# Builds the g729Control testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module g729ControlTb -f g729Control.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/Vg729ControlTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1
